//--- testbench/line_vectors.txt
# fill <cidx> <flag> and line <x0> <y0> <x1> <y1> <cidx> <flag> with flag done, reject or drop
# frame <background rgb> then px <x> <y> <rgb> for each pixel that differs from the background
fill 1 done
frame f80
# all eight octants, a point, a horizontal and a vertical line on black
fill 0 done
line 0 0 4 2 1 done
line 6 0 8 4 2 done
line 12 0 10 4 3 done
line 18 0 14 2 1 done
line 18 7 14 5 2 done
line 12 9 10 5 3 done
line 6 9 8 5 1 done
line 0 7 4 5 2 done
line 20 3 20 3 3 done
line 20 10 31 10 1 done
line 31 15 31 12 2 done
frame 000
px 0 0 f80 px 1 1 f80 px 2 1 f80 px 3 2 f80 px 4 2 f80
px 6 0 0ff px 7 1 0ff px 7 2 0ff px 8 3 0ff px 8 4 0ff
px 12 0 fff px 11 1 fff px 11 2 fff px 10 3 fff px 10 4 fff
px 18 0 f80 px 17 1 f80 px 16 1 f80 px 15 2 f80 px 14 2 f80
px 18 7 0ff px 17 6 0ff px 16 6 0ff px 15 5 0ff px 14 5 0ff
px 12 9 fff px 11 8 fff px 11 7 fff px 10 6 fff px 10 5 fff
px 6 9 f80 px 7 8 f80 px 7 7 f80 px 8 6 f80 px 8 5 f80
px 0 7 0ff px 1 6 0ff px 2 6 0ff px 3 5 0ff px 4 5 0ff
px 20 3 fff
px 20 10 f80 px 21 10 f80 px 22 10 f80 px 23 10 f80 px 24 10 f80 px 25 10 f80
px 26 10 f80 px 27 10 f80 px 28 10 f80 px 29 10 f80 px 30 10 f80 px 31 10 f80
px 31 15 0ff px 31 14 0ff px 31 13 0ff px 31 12 0ff
# strobes during a fill are dropped and lines off the buffer are rejected
fill 2 done
line 0 0 5 0 3 drop
fill 3 drop
line 0 0 32 0 3 reject
line -1 2 4 2 3 reject
line 3 3 5 16 1 reject
frame 0ff

//--- tb.f
+incdir+src
src/line_display_pkg.sv
src/display_timing.sv
src/draw_cmd_decode.sv
src/line_rasterizer.sv
src/framebuffer_scanout.sv
src/line_display_top.sv
testbench/tb_line_display.sv

//--- Bender.yml
package:
  name: line_display

sources:
  - include_dirs:
      - src
    files:
      - src/line_display_pkg.sv
      - src/display_timing.sv
      - src/draw_cmd_decode.sv
      - src/line_rasterizer.sv
      - src/framebuffer_scanout.sv
      - src/line_display_top.sv

  - target: any(simulation, test)
    include_dirs:
      - src
    files:
      - testbench/tb_line_display.sv

//--- testbench/tb_line_display.sv
/*
 * line display testbench
 * replays draw commands from a vectors file and checks raster timing and frames
 */
`default_nettype none
`timescale 1ns/10ps

`include "line_display_defines.svh"

module tb_line_display
    import line_display_pkg::*;
();

    localparam int DONE_WAIT   = 2000;                      // longer than a 512 pixel fill
    localparam int REJECT_WAIT = 16;
    localparam int VSYNC_WAIT  = 2 * `H_TOTAL * `V_TOTAL;  // two frame periods
    localparam int FB_PIX      = `FB_W * `FB_H;

    logic      clk_pix;
    logic      arst_n;
    logic      cmd_valid;
    draw_cmd_u cmd;
    logic      cmd_reject;
    logic      done;
    video_t    video;

    int                  done_count;
    int                  reject_count;
    int                  exp_done;          // accepted commands so far
    int                  exp_reject;
    logic                frame_pending;     // expected frame waiting for its check
    logic [3*`CHANW-1:0] exp_frame [0:FB_PIX-1];

    line_display_top i_line_display_top (
        .clk_pix    (clk_pix),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_reject (cmd_reject),
        .done       (done),
        .video      (video)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;     // 4 ns period
    end

    // strobe counters, sampled at the edge that launches them
    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            done_count   <= 0;
            reject_count <= 0;
        end else begin
            if (done)
                done_count <= done_count + 1;
            if (cmd_reject)
                reject_count <= reject_count + 1;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [3*`CHANW-1:0] rgb_of(input video_t v);
        return {v.red, v.green, v.blue};
    endfunction

    function automatic draw_cmd_u fill_word(input int ci);
        draw_cmd_u c;
        c             = '0;
        c.fill_v.op   = `OP_FILL;
        c.fill_v.cidx = `CIDXW'(ci);
        return c;
    endfunction

    function automatic draw_cmd_u line_word(input int x0, input int y0,
                                            input int x1, input int y1, input int ci);
        draw_cmd_u c;
        c             = '0;
        c.line_v.op   = ~`OP_FILL;
        c.line_v.x0   = `CORDW'(x0);        // negative values wrap to signed field
        c.line_v.y0   = `CORDW'(y0);
        c.line_v.x1   = `CORDW'(x1);
        c.line_v.y1   = `CORDW'(y1);
        c.line_v.cidx = `CIDXW'(ci);
        return c;
    endfunction

    task automatic wait_done_total(input int target);
        int n;
        n = 0;
        while (done_count < target && n < DONE_WAIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (done_count < target)
            stop_with_failure("timed out waiting for the done strobe");
    endtask

    task automatic wait_reject_total(input int target);
        int n;
        n = 0;
        while (reject_count < target && n < REJECT_WAIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (reject_count < target)
            stop_with_failure("timed out waiting for cmd_reject");
    endtask

    task automatic wait_vsync_rise;
        logic prev;
        int   n;
        prev = 1'b1;                        // a rise needs a low sample first
        n    = 0;
        while (!(video.vsync && !prev) && n < VSYNC_WAIT) begin
            prev = video.vsync;
            @(negedge clk_pix);
            n++;
        end
        if (!(video.vsync && !prev))
            stop_with_failure("no rising vsync on the video output within the timeout");
    endtask

    task automatic send_cmd(input draw_cmd_u c);
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk_pix);
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    // one full frame between vsync rises
    task automatic check_raster;
        int   cycles;
        int   de_run;
        int   hs_run;
        int   lines;
        int   hs_lines;
        logic prev_vs;
        logic rose;
        wait_vsync_rise();
        cycles   = 0;
        de_run   = 0;
        hs_run   = 0;
        lines    = 0;
        hs_lines = 0;
        prev_vs  = 1'b1;
        rose     = 1'b0;
        while (!rose && cycles < VSYNC_WAIT) begin
            @(negedge clk_pix);
            cycles++;
            if (video.de) begin
                de_run++;
            end else begin
                if (de_run != 0) begin
                    check_value("de run length", de_run, `H_ACTIVE);
                    lines++;
                end
                de_run = 0;
                check_value("video rgb in blanking", rgb_of(video), 0);
            end
            if (video.hsync) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_value("hsync width", hs_run, `H_SYNC_END - `H_SYNC_START);
                hs_lines++;
                hs_run = 0;
            end
            rose    = video.vsync && !prev_vs;
            prev_vs = video.vsync;
        end
        if (!rose)
            stop_with_failure("vsync did not rise again within the timeout");
        check_value("vsync period", cycles, `H_TOTAL * `V_TOTAL);
        check_value("active lines", lines, `V_ACTIVE);
        check_value("hsync pulses", hs_lines, `V_TOTAL);
    endtask

    task automatic check_frame;
        int n;
        int cycles;
        wait_vsync_rise();
        n      = 0;
        cycles = 0;
        while (n < FB_PIX && cycles < VSYNC_WAIT) begin
            @(negedge clk_pix);
            cycles++;
            if (video.de) begin
                check_value($sformatf("video rgb at x %0d y %0d", n % `FB_W, n / `FB_W),
                            rgb_of(video), exp_frame[n]);
                n++;                        // raster order matches buffer order
            end else begin
                check_value("video rgb in blanking", rgb_of(video), 0);
            end
        end
        if (n < FB_PIX)
            stop_with_failure("frame ended before every active pixel was seen");
    endtask

    task automatic finish_frame;
        if (frame_pending) begin
            wait_done_total(exp_done);
            wait_reject_total(exp_reject);
            check_frame();
            check_value("done count", done_count, exp_done);     // catches stray jobs
            check_value("reject count", reject_count, exp_reject);
            frame_pending = 1'b0;
        end
    endtask

    task automatic issue_cmd(input draw_cmd_u c, input logic [63:0] flag);
        if (flag == "drop") begin
            repeat (3) @(negedge clk_pix);  // lands inside the running fill
            send_cmd(c);
        end else if (flag == "done" || flag == "reject") begin
            wait_done_total(exp_done);      // engine idle first
            wait_reject_total(exp_reject);
            send_cmd(c);
            if (flag == "done") begin
                exp_done++;
            end else begin
                exp_reject++;
                wait_reject_total(exp_reject);
                check_value("done count after reject", done_count, exp_done);
            end
        end else begin
            stop_with_failure("unknown flag in the vectors file");
        end
    endtask

    task automatic run_vectors;
        int               fd;
        int               r;
        int               i;
        int               x0;
        int               y0;
        int               x1;
        int               y1;
        int               ci;
        logic [63:0]      kw;
        logic [63:0]      flag;
        logic [11:0]      colour;
        logic [8*160-1:0] rest;
        fd = $fopen("testbench/line_vectors.txt", "r");
        if (fd == 0)
            stop_with_failure("cannot open testbench/line_vectors.txt");
        kw = '0;
        r  = $fscanf(fd, "%s", kw);
        while (r == 1) begin
            flag = '0;
            if (kw == "#") begin
                r = $fgets(rest, fd);       // skip comment text
            end else if (kw == "fill") begin
                r = $fscanf(fd, "%d %s", ci, flag);
                if (r != 2)
                    stop_with_failure("malformed fill record in the vectors file");
                finish_frame();
                issue_cmd(fill_word(ci), flag);
            end else if (kw == "line") begin
                r = $fscanf(fd, "%d %d %d %d %d %s", x0, y0, x1, y1, ci, flag);
                if (r != 6)
                    stop_with_failure("malformed line record in the vectors file");
                finish_frame();
                issue_cmd(line_word(x0, y0, x1, y1, ci), flag);
            end else if (kw == "frame") begin
                r = $fscanf(fd, "%h", colour);
                finish_frame();
                for (i = 0; i < FB_PIX; i++)
                    exp_frame[i] = colour;  // background of the last fill
                frame_pending = 1'b1;
            end else if (kw == "px") begin
                r = $fscanf(fd, "%d %d %h", x0, y0, colour);
                if (r != 3)
                    stop_with_failure("malformed pixel record in the vectors file");
                exp_frame[y0 * `FB_W + x0] = colour;
            end else begin
                stop_with_failure("unknown record in the vectors file");
            end
            kw = '0;
            r  = $fscanf(fd, "%s", kw);
        end
        $fclose(fd);
        finish_frame();                     // last frame has no record after it
    endtask

    initial begin
        arst_n        = 1'b0;
        cmd_valid     = 1'b0;
        cmd           = '0;
        exp_done      = 0;
        exp_reject    = 0;
        frame_pending = 1'b0;
        repeat (16) begin
            @(negedge clk_pix);
            check_value("video during reset", video, 0);
            check_value("done during reset", done, 0);
            check_value("cmd_reject during reset", cmd_reject, 0);
        end
        arst_n = 1'b1;
        check_raster();
        run_vectors();
        repeat (2 * `H_TOTAL) @(negedge clk_pix);   // room for a late strobe
        check_value("final done count", done_count, exp_done);
        check_value("final reject count", reject_count, exp_reject);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/line_display_top.sv
/*
 * line display top
 * raster timing, command decode, rasterizer and framebuffer scanout
 */
`default_nettype none
`timescale 1ns/10ps

`include "line_display_defines.svh"

module line_display_top
    import line_display_pkg::*;
(
    input  wire logic      clk_pix,
    input  wire logic      arst_n,
    input  wire logic      cmd_valid,   // host strobe
    input  wire draw_cmd_u cmd,
    output logic           cmd_reject,
    output logic           done,
    output video_t         video
);

    logic [`CORDW-1:0] sx;
    logic [`CORDW-1:0] sy;
    logic              hsync;
    logic              vsync;
    logic              de;
    logic              job_start;
    logic              busy;
    draw_job_t         job;
    pix_wr_t           wr;

    display_timing i_display_timing (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   ()         // drawing is not frame locked
    );

    draw_cmd_decode i_draw_cmd_decode (
        .clk_pix    (clk_pix),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .job_start  (job_start),
        .job        (job),
        .cmd_reject (cmd_reject)
    );

    line_rasterizer i_line_rasterizer (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .job_start (job_start),
        .job       (job),
        .busy      (busy),
        .wr        (wr),
        .done      (done)
    );

    framebuffer_scanout i_framebuffer_scanout (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .wr      (wr),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .video   (video)
    );

endmodule

`default_nettype wire

//--- src/framebuffer_scanout.sv
/*
 * framebuffer scanout
 * colour index memory read in raster order, palette lookup, aligned video
 */
`default_nettype none
`timescale 1ns/10ps

`include "line_display_defines.svh"

module framebuffer_scanout
    import line_display_pkg::*;
(
    input  wire logic              clk_pix,
    input  wire logic              arst_n,
    input  wire pix_wr_t           wr,      // from rasterizer
    input  wire logic [`CORDW-1:0] sx,
    input  wire logic [`CORDW-1:0] sy,
    input  wire logic              hsync,
    input  wire logic              vsync,
    input  wire logic              de,
    output video_t                 video
);

    logic [`CIDXW-1:0]   mem [0:(1 << `FB_AW) - 1];   // one index per pixel
    logic [`FB_AW-1:0]   rd_addr;
    logic [`CIDXW-1:0]   rd_cidx;                     // valid one cycle after de
    logic                hsync_q;
    logic                vsync_q;
    logic                de_q;
    logic [3*`CHANW-1:0] colour;

    always_ff @(posedge clk_pix) begin
        if (wr.we)
            mem[wr.addr] <= wr.cidx;
    end

    assign rd_addr = `FB_AW'(sy * `FB_W + sx);    // only meaningful during de

    // separate read port, same-address write gives old data
    always_ff @(posedge clk_pix) begin
        if (de)
            rd_cidx <= mem[rd_addr];
    end

    // match the one cycle memory read
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            de_q    <= 1'b0;
        end else begin
            hsync_q <= hsync;
            vsync_q <= vsync;
            de_q    <= de;
        end
    end

    always_comb begin
        colour      = de_q ? PALETTE[rd_cidx] : '0;   // black in blanking
        video.hsync = hsync_q;
        video.vsync = vsync_q;
        video.de    = de_q;
        video.red   = colour[3*`CHANW-1 -: `CHANW];
        video.green = colour[2*`CHANW-1 -: `CHANW];
        video.blue  = colour[`CHANW-1 -: `CHANW];
    end

endmodule

`default_nettype wire

//--- src/line_rasterizer.sv
/*
 * line rasterizer
 * bresenham line walk or full buffer fill, one pixel write per clock
 */
`default_nettype none
`timescale 1ns/10ps

`include "line_display_defines.svh"

module line_rasterizer
    import line_display_pkg::*;
(
    input  wire logic      clk_pix,
    input  wire logic      arst_n,
    input  wire logic      job_start,
    input  wire draw_job_t job,
    output logic           busy,
    output pix_wr_t        wr,
    output logic           done     // cycle after final write
);

    draw_job_t                job_q;    // held for the whole job
    logic                     drawing;
    logic                     last;
    logic                     is_fill;
    logic signed [`CORDW-1:0] x;
    logic signed [`CORDW-1:0] y;
    logic signed [`CORDW-1:0] x_n;
    logic signed [`CORDW-1:0] y_n;
    logic signed [`ERRW-1:0]  err;
    logic signed [`ERRW-1:0]  err_n;
    logic signed [`ERRW-1:0]  dx_e;
    logic signed [`ERRW-1:0]  dy_e;
    logic signed [`ERRW:0]    e2;       // twice the error
    logic                     step_x;
    logic                     step_y;

    assign is_fill = (job_q.mode == `OP_FILL);
    assign dx_e    = $signed(`ERRW'(job_q.dx));
    assign dy_e    = $signed(`ERRW'(job_q.dy));
    assign e2      = $signed({err, 1'b0});
    assign step_x  = (e2 >= -dy_e);
    assign step_y  = (e2 <= dx_e);

    assign last = is_fill ? ((x == `FB_W - 1) && (y == `FB_H - 1))
                          : ((x == job_q.x1) && (y == job_q.y1));   // both ends drawn

    always_comb begin
        x_n   = x;
        y_n   = y;
        err_n = err;
        if (is_fill) begin
            if (x == `FB_W - 1) begin
                x_n = '0;           // next row
                y_n = y + 1'b1;
            end else begin
                x_n = x + 1'b1;
            end
        end else begin
            if (step_x) begin
                err_n = err_n - dy_e;
                x_n   = job_q.x_neg ? x - 1'b1 : x + 1'b1;
            end
            if (step_y) begin
                err_n = err_n + dx_e;
                y_n   = job_q.y_neg ? y - 1'b1 : y + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            drawing <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= drawing && last;
            if (job_start)
                drawing <= 1'b1;
            else if (drawing && last)
                drawing <= 1'b0;
        end
    end

    // walk position and error, loaded at job start
    always_ff @(posedge clk_pix) begin
        if (job_start) begin
            job_q <= job;
            x     <= (job.mode == `OP_FILL) ? '0 : job.x0;
            y     <= (job.mode == `OP_FILL) ? '0 : job.y0;
            err   <= $signed(`ERRW'(job.dx)) - $signed(`ERRW'(job.dy));
        end else if (drawing && !last) begin
            x   <= x_n;
            y   <= y_n;
            err <= err_n;
        end
    end

    assign busy = drawing;

    always_comb begin
        wr.we   = drawing;
        wr.addr = `FB_AW'(y * `FB_W + x);   // row major
        wr.cidx = job_q.cidx;
    end

endmodule

`default_nettype wire

//--- src/draw_cmd_decode.sv
/*
 * draw command decode
 * takes host strobes while idle, bounds-checks lines, builds the job
 */
`default_nettype none
`timescale 1ns/10ps

`include "line_display_defines.svh"

module draw_cmd_decode
    import line_display_pkg::*;
(
    input  wire logic      clk_pix,
    input  wire logic      arst_n,
    input  wire logic      cmd_valid,   // one-cycle strobe
    input  wire draw_cmd_u cmd,
    input  wire logic      busy,        // engine running
    output logic           job_start,
    output draw_job_t      job,
    output logic           cmd_reject   // line out of bounds
);

    logic                  accept;
    logic                  is_fill;
    logic                  in_bounds;
    logic signed [`CORDW:0] dx_raw;     // one extra bit for the sign
    logic signed [`CORDW:0] dy_raw;
    draw_job_t             job_d;

    function automatic logic in_buf(input logic signed [`CORDW-1:0] x,
                                    input logic signed [`CORDW-1:0] y);
        in_buf = (x >= 0) && (x < `FB_W) && (y >= 0) && (y < `FB_H);
    endfunction

    function automatic logic [`CORDW-1:0] abs_delta(input logic signed [`CORDW:0] d);
        abs_delta = d[`CORDW] ? `CORDW'(-d) : `CORDW'(d);
    endfunction

    assign accept    = cmd_valid && !busy && !job_start;   // drop while engine taken
    assign is_fill   = (cmd.fill_v.op == `OP_FILL);
    assign in_bounds = in_buf(cmd.line_v.x0, cmd.line_v.y0)
                    && in_buf(cmd.line_v.x1, cmd.line_v.y1);

    always_comb begin
        dx_raw      = (`CORDW+1)'(cmd.line_v.x1) - (`CORDW+1)'(cmd.line_v.x0);
        dy_raw      = (`CORDW+1)'(cmd.line_v.y1) - (`CORDW+1)'(cmd.line_v.y0);
        job_d.mode  = cmd.fill_v.op;
        job_d.x0    = cmd.line_v.x0;
        job_d.y0    = cmd.line_v.y0;
        job_d.x1    = cmd.line_v.x1;
        job_d.y1    = cmd.line_v.y1;
        job_d.dx    = abs_delta(dx_raw);
        job_d.dy    = abs_delta(dy_raw);
        job_d.x_neg = dx_raw[`CORDW];
        job_d.y_neg = dy_raw[`CORDW];
        job_d.cidx  = cmd.fill_v.cidx;  // same bits in both views
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            job_start  <= 1'b0;
            cmd_reject <= 1'b0;
        end else begin
            job_start  <= accept && (is_fill || in_bounds);
            cmd_reject <= accept && !is_fill && !in_bounds;
        end
    end

    // job payload only moves on an accepted strobe
    always_ff @(posedge clk_pix) begin
        if (accept)
            job <= job_d;
    end

endmodule

`default_nettype wire

//--- src/display_timing.sv
/*
 * display timing
 * raster counters with registered sync, data enable and frame strobe
 */
`default_nettype none
`timescale 1ns/10ps

`include "line_display_defines.svh"

module display_timing (
    input  wire logic          clk_pix,
    input  wire logic          arst_n,
    output logic [`CORDW-1:0]  sx,      // column, up to H_TOTAL-1
    output logic [`CORDW-1:0]  sy,      // line, up to V_TOTAL-1
    output logic               hsync,   // active high
    output logic               vsync,
    output logic               de,
    output logic               frame    // strobe at 0,0
);

    logic [`CORDW-1:0] h_next;
    logic [`CORDW-1:0] v_next;

    always_comb begin
        h_next = sx + 1'b1;
        v_next = sy;
        if (sx == `H_TOTAL - 1) begin
            h_next = '0;            // wrap column
            v_next = sy + 1'b1;
            if (sy == `V_TOTAL - 1)
                v_next = '0;        // wrap frame
        end
    end

    // outputs follow the next position so all stay aligned
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= `CORDW'(`H_TOTAL - 1);   // next tick lands on 0,0
            sy    <= `CORDW'(`V_TOTAL - 1);
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= h_next;
            sy    <= v_next;
            hsync <= (h_next >= `H_SYNC_START) && (h_next < `H_SYNC_END);
            vsync <= (v_next == `V_SYNC_LINE);
            de    <= (h_next < `H_ACTIVE) && (v_next < `V_ACTIVE);
            frame <= (h_next == 0) && (v_next == 0);
        end
    end

endmodule

`default_nettype wire

//--- src/line_display_pkg.sv
/*
 * line display package
 * command union, job and pixel-write structs, video bus and palette
 */
`default_nettype none

`include "line_display_defines.svh"

package line_display_pkg;

    typedef struct packed {
        logic                                    op;    // 0 for line
        logic [`CMD_W-4*`CORDW-`CIDXW-2:0]       rsvd;
        logic signed [`CORDW-1:0]                x0;
        logic signed [`CORDW-1:0]                y0;
        logic signed [`CORDW-1:0]                x1;
        logic signed [`CORDW-1:0]                y1;
        logic [`CIDXW-1:0]                       cidx;
    } line_cmd_t;

    typedef struct packed {
        logic                                    op;    // 1 for fill
        logic [`CMD_W-`CIDXW-2:0]                rsvd;
        logic [`CIDXW-1:0]                       cidx;
    } fill_cmd_t;

    // same word, opcode bit picks the view
    typedef union packed {
        line_cmd_t line_v;
        fill_cmd_t fill_v;
    } draw_cmd_u;

    typedef struct packed {
        logic                     mode;     // OP_FILL or line
        logic signed [`CORDW-1:0] x0;
        logic signed [`CORDW-1:0] y0;
        logic signed [`CORDW-1:0] x1;
        logic signed [`CORDW-1:0] y1;
        logic [`CORDW-1:0]        dx;       // abs delta
        logic [`CORDW-1:0]        dy;
        logic                     x_neg;    // step left
        logic                     y_neg;    // step up
        logic [`CIDXW-1:0]        cidx;
    } draw_job_t;

    typedef struct packed {
        logic              we;
        logic [`FB_AW-1:0] addr;
        logic [`CIDXW-1:0] cidx;
    } pix_wr_t;

    typedef struct packed {
        logic              hsync;
        logic              vsync;
        logic              de;
        logic [`CHANW-1:0] red;
        logic [`CHANW-1:0] green;
        logic [`CHANW-1:0] blue;
    } video_t;

    // white, cyan, orange, black from index 3 down to 0
    localparam logic [2**`CIDXW-1:0][3*`CHANW-1:0] PALETTE = {
        12'hfff, 12'h0ff, 12'hf80, 12'h000
    };

endpackage

`default_nettype wire

//--- src/line_display_defines.svh
/*
 * line display defines
 * buffer geometry, reduced raster timing and field widths
 */
`ifndef LINE_DISPLAY_DEFINES_SVH
`define LINE_DISPLAY_DEFINES_SVH

`define FB_W         32             // buffer width in pixels
`define FB_H         16             // buffer height in lines
`define FB_AW        9              // buffer address width
`define CORDW        6              // coordinate width, signed
`define CIDXW        2              // colour index width
`define CHANW        4              // bits per colour channel
`define CMD_W        32             // host command word
`define ERRW         (`CORDW + 2)   // bresenham error term
`define OP_FILL      1'b1           // opcode bit, 0 means line

`define H_ACTIVE     32             // visible columns
`define H_SYNC_START 34
`define H_SYNC_END   36             // first column after hsync
`define H_TOTAL      40
`define V_ACTIVE     16             // visible lines
`define V_SYNC_LINE  17
`define V_TOTAL      20

`endif
